// File: flist.f
src/rvPkg.sv
src/stageReg.sv
src/fetchStage.sv
src/controlDecoder.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/cpuTop.sv
sim/cpuTb.sv

// File: sim/cpuTb.sv
/*
 * testbench for the pipelined RV32I core
 * instruction and data memory models, instruction encoders,
 * directed tests for reset, ALU ops, loads, branches, jal and x0
 */

`timescale 1ns/1ps

module cpuTb;

    import rvPkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 256;
    localparam int RUN_RESET    = 8;
    localparam int RUN_ARITH    = 28;
    localparam int RUN_LOAD     = 14;
    localparam int RUN_BRANCH   = 21;
    localparam int RUN_JUMP     = 18;
    localparam int ARITH_ROUNDS = 3;
    localparam int WATCHDOG_CYCLES = (ARITH_ROUNDS + 4) * (RESET_CYCLES + 2) + RUN_RESET
        + ARITH_ROUNDS * RUN_ARITH + RUN_LOAD + RUN_BRANCH + RUN_JUMP + 50;
    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] pc;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic        memWrite;
    logic [31:0] result;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] logAddr [$];
    logic [31:0] logData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          progLen;
    int          seed = 61286;

    cpuTop i_dut (
        .instr     (instr),
        .readData  (readData),
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        if (addr < RESET_PC || offset[31:2] >= IMEM_WORDS) begin
            return NOP;
        end
        return imem[offset[31:2]];
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return 32'hC0DE_0000 ^ (addr * 32'h0001_0101);
    endfunction

    // memories answer on the falling edge
    always @(negedge clk) begin
        if (memWrite === 1'b1) begin
            dmem[aluResult[9:2]] = writeData;
            logAddr.push_back(aluResult);
            logData.push_back(writeData);
        end
        instr    <= fetchWord(pc);
        readData <= dmem[aluResult[9:2]];
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] loadWord(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchEq(input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jumpLink(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic put(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // loaded on a rising edge, away from the memory process
    task automatic clearProgram();
        @(posedge clk);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fillWord(32'(i * 4));
        end
        progLen = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        logAddr.delete();
        logData.delete();
        rst = 1'b0; // now in cycle 0, pc at RESET_PC
    endtask

    task automatic runCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic compareStores();
        compareValue("storeCount", 32'(logAddr.size()), 32'(expAddr.size()));
        foreach (expAddr[i]) begin
            compareValue($sformatf("storeAddr[%0d]", i), logAddr[i], expAddr[i]);
            compareValue($sformatf("storeData[%0d]", i), logData[i], expData[i]);
        end
    endtask

    task automatic resetTest();
        clearProgram();
        applyReset();
        compareValue("pc", pc, RESET_PC);
        compareValue("memWrite", 32'(memWrite), 32'd0);
        compareValue("result", result, 32'd0);
        for (int k = 1; k <= RUN_RESET; k++) begin
            runCycles(1);
            compareValue("pc", pc, RESET_PC + 32'(4 * k));
        end
    endtask

    task automatic arithTest();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] immC;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] want [9];
        immA = 12'($random(seed));
        immB = 12'($random(seed));
        immC = 12'($random(seed));
        a = {{20{immA[11]}}, immA};
        b = {{20{immB[11]}}, immB};
        c = {{20{immC[11]}}, immC};
        want[0] = a + b;
        want[1] = a - b;
        want[2] = a & b;
        want[3] = a | b;
        want[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        want[5] = a + c;
        want[6] = a & c;
        want[7] = a | c;
        want[8] = ($signed(a) < $signed(c)) ? 32'd1 : 32'd0;
        clearProgram();
        put(iType(immA, 5'd0, 3'b000, 5'd1));
        put(iType(immB, 5'd0, 3'b000, 5'd2));
        put(NOP);
        put(NOP);
        put(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        put(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // sub
        put(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        put(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        put(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd7));
        put(iType(immC, 5'd1, 3'b000, 5'd8));
        put(iType(immC, 5'd1, 3'b111, 5'd9));
        put(iType(immC, 5'd1, 3'b110, 5'd10));
        put(iType(immC, 5'd1, 3'b010, 5'd11));
        for (int k = 0; k < 9; k++) begin
            put(storeWord(5'(k + 3), 5'd0, 12'(32'h100 + 4 * k)));
            expectStore(32'h100 + 32'(4 * k), want[k]);
        end
        applyReset();
        runCycles(RUN_ARITH);
        compareStores();
    endtask

    task automatic loadTest();
        logic [31:0] src [3];
        clearProgram();
        for (int k = 0; k < 3; k++) begin
            src[k] = ({$random(seed)} % 64) * 4;
            put(loadWord(5'(k + 1), 5'd0, src[k][11:0]));
        end
        put(NOP);
        put(NOP);
        for (int k = 0; k < 3; k++) begin
            put(storeWord(5'(k + 1), 5'd0, 12'(32'h200 + 4 * k)));
            expectStore(32'h200 + 32'(4 * k), fillWord(src[k]));
        end
        applyReset();
        runCycles(RUN_LOAD);
        compareStores();
    endtask

    task automatic branchTest();
        clearProgram();
        put(iType(12'd5, 5'd0, 3'b000, 5'd1));
        put(iType(12'd5, 5'd0, 3'b000, 5'd2));
        put(iType(12'd7, 5'd0, 3'b000, 5'd3));
        put(NOP);
        put(NOP);
        put(branchEq(5'd1, 5'd3, 13'h1FF8)); // not taken, would loop back to idx 3
        put(storeWord(5'd1, 5'd0, 12'h300));
        put(storeWord(5'd2, 5'd0, 12'h304));
        put(storeWord(5'd3, 5'd0, 12'h308)); // fall-through marker
        put(branchEq(5'd1, 5'd2, 13'd20));   // taken, idx 9 to idx 14
        put(storeWord(5'd1, 5'd0, 12'h30C));
        put(storeWord(5'd2, 5'd0, 12'h310));
        put(storeWord(5'd3, 5'd0, 12'h314)); // skipped
        put(NOP);
        put(storeWord(5'd3, 5'd0, 12'h318));
        expectStore(32'h300, 32'd5);
        expectStore(32'h304, 32'd5);
        expectStore(32'h308, 32'd7);
        expectStore(32'h30C, 32'd5);
        expectStore(32'h310, 32'd5);
        expectStore(32'h318, 32'd7);
        applyReset();
        runCycles(12);
        compareValue("pc", pc, RESET_PC + 32'd56);
        runCycles(RUN_BRANCH - 12);
        compareStores();
    endtask

    task automatic jumpTest();
        clearProgram();
        put(iType(12'h055, 5'd0, 3'b000, 5'd0)); // write to x0
        put(jumpLink(5'd5, 21'd28));             // idx 1 to idx 8
        put(iType(12'd1, 5'd0, 3'b000, 5'd6));
        put(iType(12'd2, 5'd0, 3'b000, 5'd7));
        put(storeWord(5'd5, 5'd0, 12'h3F0));     // skipped
        put(NOP);
        put(NOP);
        put(NOP);
        put(storeWord(5'd5, 5'd0, 12'h380));
        put(storeWord(5'd0, 5'd0, 12'h384));
        put(storeWord(5'd6, 5'd0, 12'h388));
        put(storeWord(5'd7, 5'd0, 12'h38C));
        expectStore(32'h380, RESET_PC + 32'd4 + 32'd4); // link of jal at idx 1
        expectStore(32'h384, 32'd0);
        expectStore(32'h388, 32'd1);
        expectStore(32'h38C, 32'd2);
        applyReset();
        runCycles(4);
        compareValue("pc", pc, RESET_PC + 32'd32);
        runCycles(RUN_JUMP - 4);
        compareStores();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        rst      = 1'b1;
        instr    = NOP;
        readData = '0;
        resetTest();
        for (int r = 0; r < ARITH_ROUNDS; r++) begin
            arithTest();
        end
        loadTest();
        branchTest();
        jumpTest();
        $display("TEST PASSED");
        $finish;
    end

endmodule : cpuTb

// File: src/cpuTop.sv
/*
 * five stage pipelined RV32I core, top level
 * fetch, decode, execute stages and the four stage registers
 * memories sit outside on plain ports
 */

`timescale 1ns/1ps

module cpuTop (
    input  logic [rvPkg::XLEN-1:0] instr,
    input  logic [rvPkg::XLEN-1:0] readData,
    input  logic                   clk,
    input  logic                   rst,
    output logic [rvPkg::XLEN-1:0] pc,
    output logic [rvPkg::XLEN-1:0] aluResult,
    output logic [rvPkg::XLEN-1:0] writeData,
    output logic                   memWrite,
    output logic [rvPkg::XLEN-1:0] result
);

    import rvPkg::*;

    fdT fdF, fdD;
    deT deD, deE;
    emT emE, emM;
    mwT mwM, mwW;

    logic            pcSrc;
    logic [XLEN-1:0] pcTarget;

    fetchStage fetch (
        .clk      (clk),
        .rst      (rst),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .instr    (instr),
        .pc       (pc),
        .fd       (fdF)
    );

    stageReg #(.payloadT(fdT)) regFd (.clk(clk), .rst(rst), .d(fdF), .q(fdD));

    decodeStage decode (
        .clk    (clk),
        .rst    (rst),
        .fd     (fdD),
        .mw     (mwW),
        .de     (deD),
        .result (result)
    );

    stageReg #(.payloadT(deT)) regDe (.clk(clk), .rst(rst), .d(deD), .q(deE));

    executeStage execute (
        .de       (deE),
        .em       (emE),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget)
    );

    stageReg #(.payloadT(emT)) regEm (.clk(clk), .rst(rst), .d(emE), .q(emM));

    // memory stage, data memory answers in the same cycle
    assign aluResult = emM.aluResult;
    assign writeData = emM.writeData;
    assign memWrite  = emM.memWrite;

    assign mwM = '{
        regWrite:  emM.regWrite,
        resultSrc: emM.resultSrc,
        aluResult: emM.aluResult,
        readData:  readData,
        rd:        emM.rd,
        pcPlus4:   emM.pcPlus4
    };

    stageReg #(.payloadT(mwT)) regMw (.clk(clk), .rst(rst), .d(mwM), .q(mwW));

endmodule : cpuTop

// File: src/executeStage.sv
/*
 * execute stage
 * operand b select, ALU, branch target adder, pc source decision
 */

`timescale 1ns/1ps

module executeStage (
    input  rvPkg::deT              de,
    output rvPkg::emT              em,
    output logic                   pcSrc,
    output logic [rvPkg::XLEN-1:0] pcTarget
);

    import rvPkg::*;

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic            zero;

    assign srcA = de.rd1;
    assign srcB = de.ctrl.aluSrc ? de.immExt : de.rd2;

    always_comb begin
        case (de.ctrl.aluControl)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_SLT: aluResult = XLEN'($signed(srcA) < $signed(srcB));
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq taken when the subtraction is zero
    assign pcTarget = de.pc + de.immExt;
    assign pcSrc    = (de.ctrl.branch && zero) || de.ctrl.jump;

    assign em = '{
        regWrite:  de.ctrl.regWrite,
        resultSrc: de.ctrl.resultSrc,
        memWrite:  de.ctrl.memWrite,
        aluResult: aluResult,
        writeData: de.rd2,   // store data
        rd:        de.rd,
        pcPlus4:   de.pcPlus4
    };

endmodule : executeStage

// File: src/decodeStage.sv
/*
 * decode stage
 * field extraction, immediate extension, register file
 * and the writeback result select
 */

`timescale 1ns/1ps

module decodeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  rvPkg::fdT              fd,
    input  rvPkg::mwT              mw,
    output rvPkg::deT              de,
    output logic [rvPkg::XLEN-1:0] result
);

    import rvPkg::*;

    ctrlT            ctrl;
    immSrcT          immSrc;
    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] ins;

    assign ins = fd.instr;

    controlDecoder ctrlDec (
        .instr  (ins),
        .ctrl   (ctrl),
        .immSrc (immSrc)
    );

    // writeback select, driven back into the register file
    always_comb begin
        case (mw.resultSrc)
            RES_MEM: result = mw.readData;
            RES_PC4: result = mw.pcPlus4;
            default: result = mw.aluResult;
        endcase
    end

    regFile regs (
        .clk       (clk),
        .rst       (rst),
        .writeEn   (mw.regWrite),
        .addr1     (ins[19:15]),
        .addr2     (ins[24:20]),
        .addr3     (mw.rd),
        .writeData (result),
        .read1     (rd1),
        .read2     (rd2)
    );

    always_comb begin
        case (immSrc)
            IMM_I: immExt = {{20{ins[31]}}, ins[31:20]};
            IMM_S: immExt = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B: immExt = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_J: immExt = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        endcase
    end

    assign de = '{
        ctrl:    ctrl,
        rd1:     rd1,
        rd2:     rd2,
        pc:      fd.pc,
        rd:      ins[11:7],
        immExt:  immExt,
        pcPlus4: fd.pcPlus4
    };

endmodule : decodeStage

// File: src/regFile.sv
/*
 * 32 x XLEN register file
 * written on the falling edge, two combinational reads, x0 hardwired
 */

`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         writeEn,
    input  logic [rvPkg::REG_ADDR_W-1:0] addr1,
    input  logic [rvPkg::REG_ADDR_W-1:0] addr2,
    input  logic [rvPkg::REG_ADDR_W-1:0] addr3,
    input  logic [rvPkg::XLEN-1:0]       writeData,
    output logic [rvPkg::XLEN-1:0]       read1,
    output logic [rvPkg::XLEN-1:0]       read2
);

    import rvPkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // falling edge so decode sees writeback in the same cycle
    always_ff @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[addr3] <= writeData;
        end
    end

    assign read1 = (addr1 == '0) ? '0 : regs[addr1];
    assign read2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule : regFile

// File: src/controlDecoder.sv
/*
 * control unit
 * main decoder from the opcode, ALU decoder from funct3/funct7
 */

`timescale 1ns/1ps

module controlDecoder (
    input  logic [rvPkg::XLEN-1:0] instr,
    output rvPkg::ctrlT            ctrl,
    output rvPkg::immSrcT          immSrc
);

    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       op5;
    logic       funct7b5;
    logic [1:0] aluOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign op5      = instr[5];
    assign funct7b5 = instr[30];

    // aluOp 00 add, 01 sub, 10 from funct fields
    function automatic aluOpT aluDecode(
        input logic [1:0] op,
        input logic [2:0] f3,
        input logic       rtype,
        input logic       f7
    );
        aluOpT sel;
        case (op)
            2'b00:   sel = ALU_ADD; // address calc
            2'b01:   sel = ALU_SUB; // beq compare
            default: begin
                case (f3)
                    3'b000:  sel = (rtype && f7) ? ALU_SUB : ALU_ADD;
                    3'b010:  sel = ALU_SLT;
                    3'b110:  sel = ALU_OR;
                    3'b111:  sel = ALU_AND;
                    default: sel = ALU_ADD;
                endcase
            end
        endcase
        return sel;
    endfunction

    always_comb begin
        ctrl   = '0;
        immSrc = IMM_I;
        aluOp  = 2'b00;
        case (opcode)
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_MEM;
                ctrl.aluSrc    = 1'b1;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = IMM_S;
            end
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                aluOp         = 2'b10;
            end
            OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluOp         = 2'b10;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                immSrc      = IMM_B;
                aluOp       = 2'b01;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_PC4;
                ctrl.jump      = 1'b1;
                immSrc         = IMM_J;
            end
            default: ; // unsupported, acts as nop
        endcase
        ctrl.aluControl = aluDecode(aluOp, funct3, op5, funct7b5);
    end

endmodule : controlDecoder

// File: src/fetchStage.sv
/*
 * fetch stage
 * program counter, pc+4 adder, next pc select
 */

`timescale 1ns/1ps

module fetchStage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pcSrc,
    input  logic [rvPkg::XLEN-1:0] pcTarget,
    input  logic [rvPkg::XLEN-1:0] instr,
    output logic [rvPkg::XLEN-1:0] pc,
    output rvPkg::fdT              fd
);

    import rvPkg::*;

    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcNext;

    assign pcPlus4 = pc + XLEN'(4);
    assign pcNext  = pcSrc ? pcTarget : pcPlus4; // redirect from execute

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign fd = '{pc: pc, pcPlus4: pcPlus4, instr: instr};

endmodule : fetchStage

// File: src/stageReg.sv
/*
 * generic pipeline register for any packed payload type
 */

`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0; // bubble, all control bits low
        end else begin
            q <= d;
        end
    end

endmodule : stageReg

// File: src/rvPkg.sv
/*
 * shared definitions for the pipelined RV32I core
 * widths, reset PC, opcodes, control encodings
 * and the packed payloads carried between pipeline stages
 */

package rvPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0040_0000; // text segment

    // opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } immSrcT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10 // link value for jal
    } resultSrcT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluOpT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        aluOpT     aluControl;
        logic      aluSrc;     // operand b from immediate
    } ctrlT;

    // fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcPlus4;
        logic [XLEN-1:0] instr;
    } fdT;

    // decode to execute
    typedef struct packed {
        ctrlT                  ctrl;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       immExt;
        logic [XLEN-1:0]       pcPlus4;
    } deT;

    // execute to memory
    typedef struct packed {
        logic                  regWrite;
        resultSrcT             resultSrc;
        logic                  memWrite;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       writeData;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pcPlus4;
    } emT;

    // memory to writeback
    typedef struct packed {
        logic                  regWrite;
        resultSrcT             resultSrc;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       readData;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pcPlus4;
    } mwT;

endpackage : rvPkg
